/* design/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// First instruction fetched after reset
`define RV_RESET_PC    32'h0000_0200

// Initial sp, one word below the top of the stack area
`define RV_STACK_INIT  32'h0002_7FFC

// AXI response codes
`define RV_RESP_OKAY   2'b00
`define RV_RESP_SLVERR 2'b10

`endif

/* design/rv_pkg.sv */
package rv_pkg;

	typedef logic [31:0] word_t;    // Data, address or instruction
	typedef logic [4:0]  reg_idx_t; // x0..x31

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		EQ // Branch equality test
	} alu_op_t;

	typedef enum logic [3:0] {
		ALU_REG,
		ALU_IMM,
		LUI,
		AUIPC,
		JAL,
		JALR,
		BRANCH,
		LOAD,
		STORE,
		SYSTEM, // ECALL and EBREAK
		ILLEGAL
	} op_class_t;

	typedef enum logic [2:0] {
		FETCH_ISSUE, FETCH_READ, EXECUTE, MEM_ISSUE, MEM_WAIT, FINISH, HALT
	} cpu_state_t;

endpackage

/* design/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
	input  rv_pkg::word_t     i_instr,
	output rv_pkg::reg_idx_t  o_rs1,
	output rv_pkg::reg_idx_t  o_rs2,
	output rv_pkg::reg_idx_t  o_rd,
	output rv_pkg::word_t     o_imm,
	output rv_pkg::op_class_t o_class,
	output rv_pkg::alu_op_t   o_alu_op,
	output logic              o_branch_invert
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	assign o_rd  = i_instr[11:7];
	assign o_rs1 = i_instr[19:15];
	assign o_rs2 = i_instr[24:20];

	// Sign-extended immediates of each format
	assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
	assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
	assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
	assign imm_u = {i_instr[31:12], 12'b0};
	assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

	always_comb begin
		o_class         = ILLEGAL;
		o_alu_op        = ADD; // Address and link arithmetic
		o_branch_invert = 1'b0;
		o_imm           = '0;
		case (opcode)
			7'b0110111: begin
				o_class = LUI;
				o_imm   = imm_u;
			end
			7'b0010111: begin
				o_class = AUIPC;
				o_imm   = imm_u;
			end
			7'b1101111: begin
				o_class = JAL;
				o_imm   = imm_j;
			end
			7'b1100111: begin
				o_imm = imm_i;
				if (funct3 == 3'b000)
					o_class = JALR;
			end
			7'b1100011: begin
				o_class = BRANCH;
				o_imm   = imm_b;
				o_branch_invert = funct3[0]; // BNE, BGE, BGEU
				case (funct3[2:1])
					2'b00: o_alu_op = EQ;
					2'b10: o_alu_op = SLT;
					2'b11: o_alu_op = SLTU;
					default: o_class = ILLEGAL;
				endcase
			end
			7'b0000011: begin
				o_imm = imm_i;
				if (funct3 == 3'b010)
					o_class = LOAD; // LW only
			end
			7'b0100011: begin
				o_imm = imm_s;
				if (funct3 == 3'b010)
					o_class = STORE;
			end
			7'b0010011: begin
				o_class = ALU_IMM;
				o_imm   = imm_i;
				case (funct3)
					3'b000: o_alu_op = ADD;
					3'b010: o_alu_op = SLT;
					3'b011: o_alu_op = SLTU;
					3'b100: o_alu_op = XOR;
					3'b110: o_alu_op = OR;
					3'b111: o_alu_op = AND;
					3'b001: begin
						o_alu_op = SLL;
						if (funct7 != 7'h00)
							o_class = ILLEGAL;
					end
					default: begin
						o_alu_op = (funct7 == 7'h20) ? SRA : SRL;
						if (funct7 != 7'h00 && funct7 != 7'h20)
							o_class = ILLEGAL;
					end
				endcase
			end
			7'b0110011: begin
				o_class = ALU_REG;
				case ({funct7, funct3})
					{7'h00, 3'b000}: o_alu_op = ADD;
					{7'h20, 3'b000}: o_alu_op = SUB;
					{7'h00, 3'b001}: o_alu_op = SLL;
					{7'h00, 3'b010}: o_alu_op = SLT;
					{7'h00, 3'b011}: o_alu_op = SLTU;
					{7'h00, 3'b100}: o_alu_op = XOR;
					{7'h00, 3'b101}: o_alu_op = SRL;
					{7'h20, 3'b101}: o_alu_op = SRA;
					{7'h00, 3'b110}: o_alu_op = OR;
					{7'h00, 3'b111}: o_alu_op = AND;
					default: o_class = ILLEGAL;
				endcase
			end
			7'b1110011: begin
				// ECALL or EBREAK, nothing else of SYSTEM
				if (i_instr == 32'h0000_0073 || i_instr == 32'h0010_0073)
					o_class = SYSTEM;
			end
			default: o_class = ILLEGAL;
		endcase
	end

endmodule

/* design/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
	input  rv_pkg::alu_op_t i_op,
	input  rv_pkg::word_t   i_a,
	input  rv_pkg::word_t   i_b,
	output rv_pkg::word_t   o_result
);
	import rv_pkg::*;

	logic [4:0] shamt;

	assign shamt = i_b[4:0];

	always_comb begin
		case (i_op)
			ADD:  o_result = i_a + i_b;
			SUB:  o_result = i_a - i_b;
			SLL:  o_result = i_a << shamt;
			SRL:  o_result = i_a >> shamt;
			SRA:  o_result = word_t'($signed(i_a) >>> shamt);
			XOR:  o_result = i_a ^ i_b;
			OR:   o_result = i_a | i_b;
			AND:  o_result = i_a & i_b;
			// Compares give 0 or 1
			SLT:  o_result = {31'b0, $signed(i_a) < $signed(i_b)};
			SLTU: o_result = {31'b0, i_a < i_b};
			EQ:   o_result = {31'b0, i_a == i_b};
			default: o_result = '0;
		endcase
	end

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile (
	input  logic             i_clock,
	input  logic             i_arst_n,
	input  rv_pkg::reg_idx_t i_rs1_addr,
	input  rv_pkg::reg_idx_t i_rs2_addr,
	output rv_pkg::word_t    o_rs1_data,
	output rv_pkg::word_t    o_rs2_data,
	input  logic             i_we,
	input  rv_pkg::reg_idx_t i_rd_addr,
	input  rv_pkg::word_t    i_rd_data
);
	import rv_pkg::*;

	word_t regs [32];

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
			regs[2] <= `RV_STACK_INIT; // sp
		end else if (i_we && i_rd_addr != '0) begin
			regs[i_rd_addr] <= i_rd_data;
		end
	end

	// x0 always reads as zero
	assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
	assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

/* design/rv_control.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_control (
	input  logic              i_clock,
	input  logic              i_arst_n,
	output rv_pkg::word_t     o_araddr,
	output logic              o_arvalid,
	input  logic              i_arready,
	input  rv_pkg::word_t     i_rdata,
	input  logic [1:0]        i_rresp,
	input  logic              i_rvalid,
	output logic              o_rready,
	output rv_pkg::word_t     o_awaddr,
	output logic              o_awvalid,
	input  logic              i_awready,
	output rv_pkg::word_t     o_wdata,
	output logic              o_wvalid,
	input  logic              i_wready,
	input  logic [1:0]        i_bresp,
	input  logic              i_bvalid,
	output logic              o_bready,
	output rv_pkg::word_t     o_instr,
	input  rv_pkg::reg_idx_t  i_rd,
	input  rv_pkg::word_t     i_imm,
	input  rv_pkg::op_class_t i_class,
	input  rv_pkg::alu_op_t   i_alu_op,
	input  logic              i_branch_invert,
	output rv_pkg::alu_op_t   o_alu_op,
	output rv_pkg::word_t     o_alu_a,
	output rv_pkg::word_t     o_alu_b,
	input  rv_pkg::word_t     i_alu_result,
	input  rv_pkg::word_t     i_rs1_data,
	input  rv_pkg::word_t     i_rs2_data,
	output logic              o_rd_we,
	output rv_pkg::reg_idx_t  o_rd_addr,
	output rv_pkg::word_t     o_rd_data,
	output logic              o_retire_valid,
	output rv_pkg::word_t     o_retire_pc,
	output rv_pkg::reg_idx_t  o_retire_rd,
	output rv_pkg::word_t     o_retire_value,
	output logic              o_halted,
	output logic              o_trap
);
	import rv_pkg::*;

	cpu_state_t state;
	word_t      pc;
	word_t      pc_next;
	word_t      instr;
	reg_idx_t   rd_q;      // Zero when nothing is written
	word_t      result_q;
	word_t      link;
	word_t      target;
	logic       has_rd;
	logic       taken;
	logic       aw_done;
	logic       w_done;

	assign o_instr = instr;
	assign link    = pc + 32'd4;
	assign taken   = i_alu_result[0] ^ i_branch_invert;
	assign aw_done = !o_awvalid || i_awready;
	assign w_done  = !o_wvalid || i_wready;

	always_comb begin
		case (i_class)
			ALU_REG, ALU_IMM, LUI, AUIPC, JAL, JALR, LOAD: has_rd = 1'b1;
			default: has_rd = 1'b0;
		endcase
	end

	// ALU operands, address arithmetic by default
	always_comb begin
		o_alu_a  = i_rs1_data;
		o_alu_b  = i_imm;
		o_alu_op = ADD;
		case (i_class)
			ALU_REG, BRANCH: begin
				o_alu_b  = i_rs2_data;
				o_alu_op = i_alu_op;
			end
			ALU_IMM: o_alu_op = i_alu_op;
			LUI:     o_alu_a  = '0;
			AUIPC:   o_alu_a  = pc;
			default: o_alu_op = ADD;
		endcase
	end

	always_comb begin
		case (i_class)
			JAL:     target = pc + i_imm;
			JALR:    target = {i_alu_result[31:1], 1'b0};
			BRANCH:  target = taken ? pc + i_imm : link;
			default: target = link;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state     <= FETCH_ISSUE;
			pc        <= `RV_RESET_PC;
			pc_next   <= `RV_RESET_PC;
			instr     <= '0;
			rd_q      <= '0;
			result_q  <= '0;
			o_araddr  <= '0;
			o_arvalid <= 1'b0;
			o_rready  <= 1'b0;
			o_awaddr  <= '0;
			o_awvalid <= 1'b0;
			o_wdata   <= '0;
			o_wvalid  <= 1'b0;
			o_bready  <= 1'b0;
			o_halted  <= 1'b0;
			o_trap    <= 1'b0;
		end else begin
			case (state)
				FETCH_ISSUE: begin
					if (!o_arvalid) begin
						o_arvalid <= 1'b1; // First fetch after reset
						o_araddr  <= pc;
					end else if (i_arready) begin
						o_arvalid <= 1'b0;
						o_rready  <= 1'b1;
						state     <= FETCH_READ;
					end
				end
				FETCH_READ: begin
					if (i_rvalid) begin
						o_rready <= 1'b0;
						instr    <= i_rdata;
						if (i_rresp != `RV_RESP_OKAY) begin
							o_trap   <= 1'b1;
							o_halted <= 1'b1;
							state    <= HALT;
						end else begin
							state <= EXECUTE;
						end
					end
				end
				EXECUTE: begin
					pc_next <= target;
					rd_q    <= has_rd ? i_rd : '0;
					if (!has_rd || i_rd == '0)
						result_q <= '0;
					else if (i_class == JAL || i_class == JALR)
						result_q <= link;
					else
						result_q <= i_alu_result;
					case (i_class)
						LOAD: begin
							o_arvalid <= 1'b1;
							o_araddr  <= i_alu_result;
							state     <= MEM_ISSUE;
						end
						STORE: begin
							o_awvalid <= 1'b1; // AW and W raised together
							o_awaddr  <= i_alu_result;
							o_wvalid  <= 1'b1;
							o_wdata   <= i_rs2_data;
							state     <= MEM_ISSUE;
						end
						SYSTEM, ILLEGAL: begin
							o_halted <= 1'b1; // Stop without retiring
							state    <= HALT;
						end
						default: state <= FINISH;
					endcase
				end
				MEM_ISSUE: begin
					if (i_class == LOAD) begin
						if (o_arvalid && i_arready) begin
							o_arvalid <= 1'b0;
							o_rready  <= 1'b1;
							state     <= MEM_WAIT;
						end
					end else begin
						if (i_awready)
							o_awvalid <= 1'b0;
						if (i_wready)
							o_wvalid <= 1'b0;
						if (aw_done && w_done) begin
							o_bready <= 1'b1;
							state    <= MEM_WAIT;
						end
					end
				end
				MEM_WAIT: begin
					if (o_rready && i_rvalid) begin
						o_rready <= 1'b0;
						result_q <= (rd_q != '0) ? i_rdata : '0;
						if (i_rresp != `RV_RESP_OKAY) begin
							o_trap   <= 1'b1;
							o_halted <= 1'b1;
							state    <= HALT;
						end else begin
							state <= FINISH;
						end
					end else if (o_bready && i_bvalid) begin
						o_bready <= 1'b0;
						if (i_bresp != `RV_RESP_OKAY) begin
							o_trap   <= 1'b1;
							o_halted <= 1'b1;
							state    <= HALT;
						end else begin
							state <= FINISH;
						end
					end
				end
				FINISH: begin
					// Next fetch goes out right away
					pc        <= pc_next;
					o_araddr  <= pc_next;
					o_arvalid <= 1'b1;
					state     <= FETCH_ISSUE;
				end
				default: state <= HALT;
			endcase
		end
	end

	// Write back and retire in the same cycle
	assign o_rd_we        = (state == FINISH);
	assign o_rd_addr      = rd_q;
	assign o_rd_data      = result_q;
	assign o_retire_valid = (state == FINISH);
	assign o_retire_pc    = pc;
	assign o_retire_rd    = rd_q;
	assign o_retire_value = result_q;

endmodule

/* design/rv_cpu_top.sv */
`timescale 1ns/1ps

module rv_cpu_top (
	input  logic             i_clock,
	input  logic             i_arst_n,
	output rv_pkg::word_t    o_araddr,
	output logic             o_arvalid,
	input  logic             i_arready,
	input  rv_pkg::word_t    i_rdata,
	input  logic [1:0]       i_rresp,
	input  logic             i_rvalid,
	output logic             o_rready,
	output rv_pkg::word_t    o_awaddr,
	output logic             o_awvalid,
	input  logic             i_awready,
	output rv_pkg::word_t    o_wdata,
	output logic             o_wvalid,
	input  logic             i_wready,
	input  logic [1:0]       i_bresp,
	input  logic             i_bvalid,
	output logic             o_bready,
	output logic             o_retire_valid,
	output rv_pkg::word_t    o_retire_pc,
	output rv_pkg::reg_idx_t o_retire_rd,
	output rv_pkg::word_t    o_retire_value,
	output logic             o_halted,
	output logic             o_trap
);
	import rv_pkg::*;

	word_t     instr;
	reg_idx_t  rs1;
	reg_idx_t  rs2;
	reg_idx_t  rd;
	word_t     imm;
	op_class_t op_class;
	alu_op_t   dec_alu_op;
	logic      branch_invert;
	alu_op_t   alu_op;
	word_t     alu_a;
	word_t     alu_b;
	word_t     alu_result;
	word_t     rs1_data;
	word_t     rs2_data;
	logic      rd_we;
	reg_idx_t  rd_addr;
	word_t     rd_data;

	rv_control u_control (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.o_araddr(o_araddr), .o_arvalid(o_arvalid), .i_arready(i_arready),
		.i_rdata(i_rdata), .i_rresp(i_rresp), .i_rvalid(i_rvalid), .o_rready(o_rready),
		.o_awaddr(o_awaddr), .o_awvalid(o_awvalid), .i_awready(i_awready),
		.o_wdata(o_wdata), .o_wvalid(o_wvalid), .i_wready(i_wready),
		.i_bresp(i_bresp), .i_bvalid(i_bvalid), .o_bready(o_bready),
		.o_instr(instr), .i_rd(rd), .i_imm(imm), .i_class(op_class),
		.i_alu_op(dec_alu_op), .i_branch_invert(branch_invert),
		.o_alu_op(alu_op), .o_alu_a(alu_a), .o_alu_b(alu_b), .i_alu_result(alu_result),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
		.o_rd_we(rd_we), .o_rd_addr(rd_addr), .o_rd_data(rd_data),
		.o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc),
		.o_retire_rd(o_retire_rd), .o_retire_value(o_retire_value),
		.o_halted(o_halted), .o_trap(o_trap)
	);

	rv_decoder u_decoder (
		.i_instr(instr), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
		.o_class(op_class), .o_alu_op(dec_alu_op), .o_branch_invert(branch_invert)
	);

	rv_alu u_alu (
		.i_op(alu_op), .i_a(alu_a), .i_b(alu_b), .o_result(alu_result)
	);

	rv_regfile u_regfile (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_rs1_addr(rs1), .i_rs2_addr(rs2),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
		.i_we(rd_we), .i_rd_addr(rd_addr), .i_rd_data(rd_data)
	);

endmodule

/* verif/rv_cpu_assert.sv */
`timescale 1ns/1ps

module rv_cpu_assert (
	input logic          i_clock,
	input logic          i_arst_n,
	input rv_pkg::word_t i_araddr,
	input logic          i_arvalid,
	input logic          i_arready,
	input logic          i_rready,
	input rv_pkg::word_t i_awaddr,
	input logic          i_awvalid,
	input logic          i_awready,
	input rv_pkg::word_t i_wdata,
	input logic          i_wvalid,
	input logic          i_wready,
	input logic          i_bready,
	input logic          i_retire_valid
);
	import rv_pkg::*;

	int fail_count;

	initial fail_count = 0;

	// Payload held until the transfer
	ar_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
		else begin
			fail_count++;
			$error("AR valid dropped or address changed before ready");
		end

	aw_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
		else begin
			fail_count++;
			$error("AW valid dropped or address changed before ready");
		end

	w_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata))
		else begin
			fail_count++;
			$error("W valid dropped or data changed before ready");
		end

	// Single bus, one phase active at a time
	one_outstanding: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		$onehot0({i_arvalid, i_rready, i_awvalid || i_wvalid, i_bready}))
		else begin
			fail_count++;
			$error("More than one bus transaction outstanding");
		end

	quiet_in_reset: assert property (@(posedge i_clock)
		!i_arst_n |-> !(i_arvalid || i_awvalid || i_wvalid || i_retire_valid))
		else begin
			fail_count++;
			$error("Valid or retirement asserted during reset");
		end

endmodule

bind rv_cpu_top rv_cpu_assert u_assert (
	.i_clock(i_clock),
	.i_arst_n(i_arst_n),
	.i_araddr(o_araddr),
	.i_arvalid(o_arvalid),
	.i_arready(i_arready),
	.i_rready(o_rready),
	.i_awaddr(o_awaddr),
	.i_awvalid(o_awvalid),
	.i_awready(i_awready),
	.i_wdata(o_wdata),
	.i_wvalid(o_wvalid),
	.i_wready(i_wready),
	.i_bready(o_bready),
	.i_retire_valid(o_retire_valid)
);

/* verif/rv_checker.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_checker (
	input  logic             i_clock,
	input  logic             i_arst_n,
	input  logic             i_retire_valid,
	input  rv_pkg::word_t    i_retire_pc,
	input  rv_pkg::reg_idx_t i_retire_rd,
	input  rv_pkg::word_t    i_retire_value,
	input  rv_pkg::word_t    i_araddr,
	input  logic             i_arvalid,
	input  rv_pkg::word_t    i_awaddr,
	input  logic             i_awvalid,
	input  logic             i_awready,
	input  rv_pkg::word_t    i_wdata,
	input  logic             i_wvalid,
	input  logic             i_wready,
	input  logic             i_halted,
	input  logic             i_trap,
	output int               o_retire_errors,
	output int               o_store_errors,
	output int               o_other_errors
);
	import rv_pkg::*;

	word_t    exp_pc[$];
	reg_idx_t exp_rd[$];
	word_t    exp_value[$];
	word_t    exp_addr[$];
	word_t    exp_data[$];
	int       n_retired;
	int       n_stores;
	logic     fetch_seen;
	logic     trap_seen;
	logic     aw_seen;
	logic     w_seen;
	word_t    aw_addr;
	word_t    w_data;

	initial begin
		o_retire_errors = 0;
		o_store_errors  = 0;
		o_other_errors  = 0;
		n_retired       = 0;
		n_stores        = 0;
		fetch_seen      = 1'b0;
		trap_seen       = 1'b0;
		aw_seen         = 1'b0;
		w_seen          = 1'b0;
	end

	task expect_retire(input word_t pc, input reg_idx_t rd, input word_t value);
		exp_pc.push_back(pc);
		exp_rd.push_back(rd);
		exp_value.push_back(value);
	endtask

	task expect_store(input word_t addr, input word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// Retirements in program order
	always @(posedge i_clock) begin
		if (i_arst_n && i_retire_valid) begin
			if (n_retired >= exp_pc.size()) begin
				$display("Extra retirement at pc %h beyond the %0d expected",
					i_retire_pc, exp_pc.size());
				o_retire_errors++;
			end else if (i_retire_pc !== exp_pc[n_retired] || i_retire_rd !== exp_rd[n_retired]
				|| i_retire_value !== exp_value[n_retired]) begin
				$display("FAILED %0t: retirement %0d pc %h x%0d=%h, expected pc %h x%0d=%h",
					$time, n_retired, i_retire_pc, i_retire_rd, i_retire_value,
					exp_pc[n_retired], exp_rd[n_retired], exp_value[n_retired]);
				o_retire_errors++;
			end
			n_retired++;
		end
	end

	// AW and W may transfer in different cycles
	always @(posedge i_clock) begin
		if (i_arst_n) begin
			if (i_awvalid && i_awready) begin
				aw_addr = i_awaddr;
				aw_seen = 1'b1;
			end
			if (i_wvalid && i_wready) begin
				w_data = i_wdata;
				w_seen = 1'b1;
			end
			if (aw_seen && w_seen) begin
				aw_seen = 1'b0;
				w_seen  = 1'b0;
				if (n_stores >= exp_addr.size()) begin
					$display("Extra store to %h beyond the %0d expected", aw_addr, exp_addr.size());
					o_store_errors++;
				end else if (aw_addr !== exp_addr[n_stores] || w_data !== exp_data[n_stores]) begin
					$display("FAILED %0t: store %0d [%h]=%h, expected [%h]=%h", $time, n_stores,
						aw_addr, w_data, exp_addr[n_stores], exp_data[n_stores]);
					o_store_errors++;
				end
				n_stores++;
			end
		end
	end

	always @(posedge i_clock) begin
		if (i_arst_n) begin
			if (i_arvalid && !fetch_seen) begin
				fetch_seen = 1'b1; // First fetch after reset
				if (i_araddr !== `RV_RESET_PC) begin
					$display("FAILED %0t: first read address %h, expected %h",
						$time, i_araddr, `RV_RESET_PC);
					o_other_errors++;
				end
			end
			if (i_halted && (i_arvalid || i_retire_valid)) begin
				$display("Core was still fetching or retiring after it halted, at %0t", $time);
				o_other_errors++;
			end
			if (i_trap && !trap_seen) begin
				trap_seen = 1'b1;
				$display("Core raised its trap flag unexpectedly at %0t", $time);
				o_other_errors++;
			end
		end
	end

	task finish_checks;
		if (!fetch_seen) begin
			$display("No instruction fetch was seen after reset");
			o_other_errors++;
		end
		if (n_retired < exp_pc.size()) begin
			$display("Missing retirements: saw %0d of %0d", n_retired, exp_pc.size());
			o_retire_errors++;
		end
		if (n_stores < exp_addr.size()) begin
			$display("Missing stores: saw %0d of %0d", n_stores, exp_addr.size());
			o_store_errors++;
		end
	endtask

endmodule

/* verif/tb_rv_cpu.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_cpu;
	import rv_pkg::*;

	localparam int mem_words = 'hA000; // Bytes 0 to the stack top
	localparam int vec_words = 256;

	logic       clock;
	logic       arst_n;
	word_t      araddr;
	logic       arvalid;
	logic       arready;
	word_t      rdata;
	logic [1:0] rresp;
	logic       rvalid;
	logic       rready;
	word_t      awaddr;
	logic       awvalid;
	logic       awready;
	word_t      wdata;
	logic       wvalid;
	logic       wready;
	logic [1:0] bresp;
	logic       bvalid;
	logic       bready;
	logic       retire_valid;
	word_t      retire_pc;
	reg_idx_t   retire_rd;
	word_t      retire_value;
	logic       halted;
	logic       trap;
	int         retire_errors;
	int         store_errors;
	int         other_errors;
	int         load_errors;
	int         ret_count;
	logic       loaded;
	logic [15:0] lfsr;
	word_t      vec [0:vec_words-1];
	word_t      mem [0:mem_words-1];

	rv_cpu_top UUT (
		.i_clock(clock), .i_arst_n(arst_n),
		.o_araddr(araddr), .o_arvalid(arvalid), .i_arready(arready),
		.i_rdata(rdata), .i_rresp(rresp), .i_rvalid(rvalid), .o_rready(rready),
		.o_awaddr(awaddr), .o_awvalid(awvalid), .i_awready(awready),
		.o_wdata(wdata), .o_wvalid(wvalid), .i_wready(wready),
		.i_bresp(bresp), .i_bvalid(bvalid), .o_bready(bready),
		.o_retire_valid(retire_valid), .o_retire_pc(retire_pc),
		.o_retire_rd(retire_rd), .o_retire_value(retire_value),
		.o_halted(halted), .o_trap(trap)
	);

	rv_checker u_checker (
		.i_clock(clock), .i_arst_n(arst_n),
		.i_retire_valid(retire_valid), .i_retire_pc(retire_pc),
		.i_retire_rd(retire_rd), .i_retire_value(retire_value),
		.i_araddr(araddr), .i_arvalid(arvalid),
		.i_awaddr(awaddr), .i_awvalid(awvalid), .i_awready(awready),
		.i_wdata(wdata), .i_wvalid(wvalid), .i_wready(wready),
		.i_halted(halted), .i_trap(trap),
		.o_retire_errors(retire_errors), .o_store_errors(store_errors),
		.o_other_errors(other_errors)
	);

	always #10 clock = ~clock;

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	task random_delay(output int cycles);
		cycles = 0;
		repeat (2) begin
			cycles = (cycles << 1) | lfsr[0];
			lfsr   = lfsr_next(lfsr);
		end
	endtask

	task load_vectors;
		int i;
		int pos;
		int count;
		$readmemh("verif/rv_cpu_vectors.mem", vec);
		if ($isunknown(vec[0])) begin
			$display("Vector file verif/rv_cpu_vectors.mem could not be read");
			load_errors++;
		end else begin
			count = vec[0];
			for (i = 0; i < count; i++)
				mem[(`RV_RESET_PC >> 2) + i] = vec[1 + i];
			pos       = 1 + count;
			ret_count = vec[pos];
			pos++;
			for (i = 0; i < ret_count; i++) begin
				u_checker.expect_retire(vec[pos], vec[pos + 1][4:0], vec[pos + 2]);
				pos += 3;
			end
			count = vec[pos];
			pos++;
			for (i = 0; i < count; i++) begin
				u_checker.expect_store(vec[pos], vec[pos + 1]);
				pos += 2;
			end
		end
	endtask

	task serve_read;
		int    wait_cycles;
		word_t addr;
		random_delay(wait_cycles);
		repeat (wait_cycles) @(negedge clock);
		addr    = araddr;
		arready = 1'b1;
		@(negedge clock);
		arready = 1'b0;
		random_delay(wait_cycles);
		repeat (wait_cycles) @(negedge clock);
		if (addr[31:2] < mem_words) begin
			rdata = mem[addr[31:2]];
			rresp = `RV_RESP_OKAY;
		end else begin
			rdata = '0;
			rresp = `RV_RESP_SLVERR; // Outside the model memory
		end
		rvalid = 1'b1;
		while (!rready) @(negedge clock);
		@(negedge clock);
		rvalid = 1'b0;
	endtask

	task serve_write;
		int    aw_wait;
		int    w_wait;
		int    b_wait;
		logic  aw_ok;
		logic  w_ok;
		word_t addr;
		word_t data;
		random_delay(aw_wait);
		random_delay(w_wait);
		aw_ok = 1'b0;
		w_ok  = 1'b0;
		// Each channel gets its own delay
		while (!(aw_ok && w_ok)) begin
			awready = (aw_wait == 0) && !aw_ok;
			wready  = (w_wait == 0) && !w_ok;
			if (awready)
				addr = awaddr;
			if (wready)
				data = wdata;
			@(negedge clock);
			aw_ok = aw_ok || awready;
			w_ok  = w_ok || wready;
			if (aw_wait > 0)
				aw_wait--;
			if (w_wait > 0)
				w_wait--;
		end
		awready = 1'b0;
		wready  = 1'b0;
		if (addr[31:2] < mem_words) begin
			mem[addr[31:2]] = data;
			bresp = `RV_RESP_OKAY;
		end else begin
			bresp = `RV_RESP_SLVERR;
		end
		random_delay(b_wait);
		repeat (b_wait) @(negedge clock);
		bvalid = 1'b1;
		while (!bready) @(negedge clock);
		@(negedge clock);
		bvalid = 1'b0;
	endtask

	// Memory model, one transaction at a time
	initial begin
		@(posedge arst_n);
		forever begin
			if (arvalid)
				serve_read();
			else if (awvalid || wvalid)
				serve_write();
			else
				@(negedge clock);
		end
	end

	initial begin
		wait (loaded);
		repeat (20 * ret_count + 100) @(posedge clock);
		$display("Run timed out after %0d cycles without the core halting",
			20 * ret_count + 100);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int i;
		clock       = 1'b0;
		arst_n      = 1'b0;
		arready     = 1'b0;
		rdata       = '0;
		rresp       = `RV_RESP_OKAY;
		rvalid      = 1'b0;
		awready     = 1'b0;
		wready      = 1'b0;
		bresp       = `RV_RESP_OKAY;
		bvalid      = 1'b0;
		lfsr        = 16'd55893;
		load_errors = 0;
		ret_count   = 0;
		loaded      = 1'b0;
		for (i = 0; i < mem_words; i++)
			mem[i] = ~word_t'(i << 2); // Pattern from the byte address
		load_vectors();
		loaded = 1'b1;
		repeat (3) @(negedge clock);
		arst_n = 1'b1;
		wait (halted);
		repeat (10) @(negedge clock); // Core must stay quiet after halt
		u_checker.finish_checks();
		$display("Errors: retire %0d, store %0d, other %0d, assertion %0d",
			retire_errors, store_errors, other_errors + load_errors, UUT.u_assert.fail_count);
		if (retire_errors + store_errors + other_errors + load_errors
			+ UUT.u_assert.fail_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* compile.f */
+incdir+design
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_control.sv
design/rv_cpu_top.sv
verif/rv_cpu_assert.sv
verif/rv_checker.sv
verif/tb_rv_cpu.sv

/* verif/rv_cpu_vectors.mem */
// Program length, then program words placed from 0x200 on
// Retirement count, then pc rd value records; store count, then address data records
1B
00010293 12345337 00001397 FFB00413 408304B3 40145513 008035B3 00042633
00700013 0FF44693 00859733 00000463 00100A13 00C59463 00045463 00806463
00200A13 008000EF 00300A13 00912023 00012783 01408867 00400A13 00D3E8B3
00B45933 009379B3 00000073
16
00000200 05 00027FFC  00000204 06 12345000
00000208 07 00001208  0000020C 08 FFFFFFFB
00000210 09 12345005  00000214 0A FFFFFFFD
00000218 0B 00000001  0000021C 0C 00000001
00000220 00 00000000  00000224 0D FFFFFF04
00000228 0E 08000000  0000022C 00 00000000
00000234 00 00000000  00000238 00 00000000
0000023C 00 00000000  00000244 01 00000248
0000024C 00 00000000  00000250 0F 12345005
00000254 10 00000258  0000025C 11 FFFFFF0C
00000260 12 7FFFFFFD  00000264 13 12345000
01
00027FFC 12345005
